//--- list.f
+incdir+include
design/arena_pkg.sv
design/move_checker.sv
design/bullet_checker.sv
design/wall_health.sv
design/tank_arena_collision.sv
verif/tb_tank_arena.sv

//--- Makefile
SRCS = include/arena_defines.svh design/arena_pkg.sv design/move_checker.sv \
       design/bullet_checker.sv design/wall_health.sv design/tank_arena_collision.sv \
       verif/tb_tank_arena.sv

obj_dir/Vtb_tank_arena: list.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_tank_arena -f list.f -Mdir obj_dir -o Vtb_tank_arena

run: obj_dir/Vtb_tank_arena
	./obj_dir/Vtb_tank_arena

clean:
	rm -rf obj_dir

.PHONY: run clean

//--- verif/tb_tank_arena.sv
`default_nettype none
`include "arena_defines.svh"

module tb_tank_arena;

  localparam int clk_period      = 20;
  localparam int reset_cycles    = 4;
  localparam int directed_cycles = 80;
  localparam int random_cycles   = 300;
  localparam int margin_cycles   = 50;

  localparam arena_pkg::coord_t tank_side   = `ARENA_TANK_SIZE;
  localparam arena_pkg::coord_t tank_step   = `ARENA_TANK_STEP;
  localparam arena_pkg::coord_t bullet_side = `ARENA_BULLET_SIZE;
  localparam arena_pkg::coord_t bullet_step = `ARENA_BULLET_STEP;

  logic Clk;
  logic Reset;
  arena_pkg::coord_t wall_x [0:`ARENA_NUM_WALLS-1];
  arena_pkg::coord_t wall_y [0:`ARENA_NUM_WALLS-1];
  arena_pkg::coord_t tank1_x, tank1_y, tank2_x, tank2_y;
  arena_pkg::coord_t bullet1_x, bullet1_y, bullet2_x, bullet2_y;
  arena_pkg::dir_t   tank1_dir, tank2_dir, bullet1_dir, bullet2_dir;
  logic can_move1, can_move2, hit1, hit2, tank1_alive, tank2_alive;
  arena_pkg::wall_count_t wall_count [0:`ARENA_NUM_WALLS-1];

  // reference model state
  arena_pkg::wall_count_t exp_count [0:`ARENA_NUM_WALLS-1];
  arena_pkg::wall_mask_t  exp_standing, exp_solid, exp_struck1, exp_struck2;
  logic exp_move1, exp_move2, exp_tank_hit1, exp_tank_hit2;
  logic [31:0] lfsr_state = 32'h796e1dc4;

  tank_arena_collision dut (.*);

  initial Clk = 1'b0;
  always #(clk_period / 2) Clk = ~Clk;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32 22 2 1
  endfunction

  function automatic int take_bits(input int n);
    int value;
    value = 0;
    for (int b = 0; b < n; b++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value = (value << 1) | int'(lfsr_state[0]);
    end
    return value;
  endfunction

  function automatic arena_pkg::coord_t shifted(input arena_pkg::coord_t base, input int delta);
    return arena_pkg::coord_t'(int'(base) + delta);
  endfunction

  function automatic arena_pkg::coord_t wall_width(input int idx);
    if (idx % 2 == 0) return `ARENA_HWALL_W;
    else return `ARENA_VWALL_W;
  endfunction

  function automatic arena_pkg::coord_t wall_height(input int idx);
    if (idx % 2 == 0) return `ARENA_HWALL_H;
    else return `ARENA_VWALL_H;
  endfunction

  // one-pixel step puts the tank edge exactly on the target face
  function automatic logic tank_meets(input arena_pkg::dir_t d,
                                      input arena_pkg::coord_t px, py, tx, ty, tw, th);
    arena_pkg::coord_t lead_pos;
    arena_pkg::coord_t face_pos;
    logic across;
    if (d == arena_pkg::dir_up || d == arena_pkg::dir_down)
      across = (arena_pkg::coord_t'(px + tank_side) > tx) && (px < arena_pkg::coord_t'(tx + tw));
    else
      across = (arena_pkg::coord_t'(py + tank_side) > ty) && (py < arena_pkg::coord_t'(ty + th));
    case (d)
      arena_pkg::dir_up: begin
        lead_pos = py - tank_step;
        face_pos = ty + th;
      end
      arena_pkg::dir_down: begin
        lead_pos = py + tank_side + tank_step;
        face_pos = ty;
      end
      arena_pkg::dir_right: begin
        lead_pos = px + tank_side + tank_step;
        face_pos = tx;
      end
      arena_pkg::dir_left: begin
        lead_pos = px - tank_step;
        face_pos = tx + tw;
      end
      default: return 1'b0;
    endcase
    return across && (lead_pos == face_pos);
  endfunction

  // five-pixel step reaches the face, and for a tank has not gone past it
  function automatic logic bullet_meets(input arena_pkg::dir_t d,
                                        input arena_pkg::coord_t bx, by, tx, ty, tw, th,
                                        input logic is_tank);
    arena_pkg::coord_t front;
    arena_pkg::coord_t back;
    logic across;
    logic reached;
    logic not_past;
    if (d == arena_pkg::dir_up || d == arena_pkg::dir_down)
      across = (arena_pkg::coord_t'(bx + bullet_side) > tx) && (bx < arena_pkg::coord_t'(tx + tw));
    else
      across = (arena_pkg::coord_t'(by + bullet_side) > ty) && (by < arena_pkg::coord_t'(ty + th));
    case (d)
      arena_pkg::dir_up: begin
        front    = by - bullet_step;
        back     = front + bullet_side;
        reached  = front <= arena_pkg::coord_t'(ty + th);
        not_past = back >= ty;
      end
      arena_pkg::dir_down: begin
        back     = by + bullet_step;
        front    = back + bullet_side;
        reached  = front >= ty;
        not_past = back <= arena_pkg::coord_t'(ty + th);
      end
      arena_pkg::dir_right: begin
        back     = bx + bullet_step;
        front    = back + bullet_side;
        reached  = front >= tx;
        not_past = back <= arena_pkg::coord_t'(tx + tw);
      end
      arena_pkg::dir_left: begin
        front    = bx - bullet_step;
        back     = front + bullet_side;
        reached  = front <= arena_pkg::coord_t'(tx + tw);
        not_past = back >= tx;
      end
      default: return 1'b0;
    endcase
    return across && reached && (!is_tank || not_past);
  endfunction

  always_comb begin
    exp_move1     = !tank_meets(tank1_dir, tank1_x, tank1_y, tank2_x, tank2_y,
                                tank_side, tank_side);
    exp_move2     = !tank_meets(tank2_dir, tank2_x, tank2_y, tank1_x, tank1_y,
                                tank_side, tank_side);
    exp_tank_hit1 = bullet_meets(bullet1_dir, bullet1_x, bullet1_y, tank2_x, tank2_y,
                                 tank_side, tank_side, 1'b1);
    exp_tank_hit2 = bullet_meets(bullet2_dir, bullet2_x, bullet2_y, tank1_x, tank1_y,
                                 tank_side, tank_side, 1'b1);
    exp_struck1   = '0;
    exp_struck2   = '0;
    for (int i = 0; i < `ARENA_NUM_WALLS; i++) begin
      exp_standing[i] = exp_count[i] < `ARENA_WALL_STAND_LIMIT;
      exp_solid[i]    = exp_count[i] <= `ARENA_WALL_SOLID_LIMIT;
      if (exp_standing[i] && tank_meets(tank1_dir, tank1_x, tank1_y, wall_x[i], wall_y[i],
                                        wall_width(i), wall_height(i)))
        exp_move1 = 1'b0;
      if (exp_standing[i] && tank_meets(tank2_dir, tank2_x, tank2_y, wall_x[i], wall_y[i],
                                        wall_width(i), wall_height(i)))
        exp_move2 = 1'b0;
      if (exp_solid[i] && exp_struck1 == '0 && bullet_meets(bullet1_dir, bullet1_x, bullet1_y,
          wall_x[i], wall_y[i], wall_width(i), wall_height(i), 1'b0))
        exp_struck1[i] = 1'b1; // first solid wall only
      if (exp_solid[i] && exp_struck2 == '0 && bullet_meets(bullet2_dir, bullet2_x, bullet2_y,
          wall_x[i], wall_y[i], wall_width(i), wall_height(i), 1'b0))
        exp_struck2[i] = 1'b1;
    end
  end

  always_ff @(posedge Clk or posedge Reset) begin
    if (Reset) begin
      for (int i = 0; i < `ARENA_NUM_WALLS; i++) exp_count[i] <= '0;
    end else begin
      for (int i = 0; i < `ARENA_NUM_WALLS; i++)
        if ((exp_struck1[i] || exp_struck2[i]) && exp_count[i] != `ARENA_WALL_DEAD)
          exp_count[i] <= exp_count[i] + 3'd1;
    end
  end

  task automatic report_mismatch(input string name, input int expected, input int actual);
    $display("CHECK FAILED at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
    $display("STATUS: FAIL");
    $fatal(1, "%s mismatch", name);
  endtask

  a_move1: assert property (@(negedge Clk) disable iff (Reset) can_move1 == exp_move1)
    else report_mismatch("can_move1", int'(exp_move1), int'(can_move1));
  a_move2: assert property (@(negedge Clk) disable iff (Reset) can_move2 == exp_move2)
    else report_mismatch("can_move2", int'(exp_move2), int'(can_move2));
  a_hit1: assert property (@(negedge Clk) disable iff (Reset)
                           hit1 == ((|exp_struck1) || exp_tank_hit1))
    else report_mismatch("hit1", int'((|exp_struck1) || exp_tank_hit1), int'(hit1));
  a_hit2: assert property (@(negedge Clk) disable iff (Reset)
                           hit2 == ((|exp_struck2) || exp_tank_hit2))
    else report_mismatch("hit2", int'((|exp_struck2) || exp_tank_hit2), int'(hit2));
  a_alive1: assert property (@(negedge Clk) disable iff (Reset) tank1_alive == !exp_tank_hit2)
    else report_mismatch("tank1_alive", int'(!exp_tank_hit2), int'(tank1_alive));
  a_alive2: assert property (@(negedge Clk) disable iff (Reset) tank2_alive == !exp_tank_hit1)
    else report_mismatch("tank2_alive", int'(!exp_tank_hit1), int'(tank2_alive));

  for (genvar i = 0; i < `ARENA_NUM_WALLS; i++) begin : g_count_chk
    a_count: assert property (@(negedge Clk) disable iff (Reset) wall_count[i] == exp_count[i])
      else report_mismatch($sformatf("wall_count[%0d]", i), int'(exp_count[i]),
                           int'(wall_count[i]));
  end

  // tank spot facing a target with slip extra pixels of gap and across sliding along the face
  task automatic spot_facing(input arena_pkg::coord_t tx, ty, tw, th, input arena_pkg::dir_t d,
                             input int slip, input int across,
                             output arena_pkg::coord_t px, output arena_pkg::coord_t py);
    int gap;
    gap = `ARENA_TANK_STEP + slip;
    px  = shifted(tx, across - 40);
    py  = shifted(ty, across - 40);
    case (d)
      arena_pkg::dir_up:    py = shifted(ty, int'(th) + gap);
      arena_pkg::dir_down:  py = shifted(ty, -(`ARENA_TANK_SIZE + gap));
      arena_pkg::dir_right: px = shifted(tx, -(`ARENA_TANK_SIZE + gap));
      arena_pkg::dir_left:  px = shifted(tx, int'(tw) + gap);
      default: px = tx;
    endcase
  endtask

  task automatic park_all();
    tank1_x <= 10'd700;
    tank1_y <= 10'd700;
    tank2_x <= 10'd800;
    tank2_y <= 10'd800;
    bullet1_x <= 10'd900;
    bullet1_y <= 10'd900;
    bullet2_x <= 10'd950;
    bullet2_y <= 10'd950;
    tank1_dir <= arena_pkg::dir_idle;
    tank2_dir <= arena_pkg::dir_idle;
    bullet1_dir <= arena_pkg::dir_idle;
    bullet2_dir <= arena_pkg::dir_idle;
  endtask

  initial begin
    #((reset_cycles + directed_cycles + random_cycles + margin_cycles) * clk_period);
    $display("watchdog expired before the stimulus finished");
    $display("STATUS: FAIL");
    $fatal(1, "timeout");
  end

  initial begin
    int w;
    int d;
    int slip;
    int across;
    int target;
    arena_pkg::coord_t px, py, qx, qy;
    Reset <= 1'b1;
    wall_x[0] <= 10'd100;
    wall_y[0] <= 10'd100;
    wall_x[1] <= 10'd300;
    wall_y[1] <= 10'd100;
    wall_x[2] <= 10'd100;
    wall_y[2] <= 10'd300;
    wall_x[3] <= 10'd500;
    wall_y[3] <= 10'd300;
    park_all();
    repeat (reset_cycles) @(posedge Clk);
    Reset <= 1'b0;

    // every face of every wall at contact, one pixel further and off to the side
    for (w = 0; w < `ARENA_NUM_WALLS; w++) begin
      for (d = 1; d <= 4; d++) begin
        for (int k = 0; k < 3; k++) begin
          spot_facing(wall_x[w], wall_y[w], wall_width(w), wall_height(w),
                      arena_pkg::dir_t'(d), (k == 1) ? 1 : 0, (k == 2) ? 0 : 48, px, py);
          @(posedge Clk);
          park_all();
          tank1_x <= px;
          tank1_y <= py;
          tank1_dir <= arena_pkg::dir_t'(d);
        end
      end
    end

    // tanks nose to nose while tank 2 turns
    for (d = 0; d <= 4; d++) begin
      @(posedge Clk);
      park_all();
      tank1_x <= 10'd600;
      tank1_y <= 10'd600;
      tank1_dir <= arena_pkg::dir_right;
      tank2_x <= 10'd633;
      tank2_y <= 10'd600;
      tank2_dir <= arena_pkg::dir_t'((d + 3) % 5);
    end

    // wear wall 1 down from below, probing tank contact in between
    spot_facing(wall_x[1], wall_y[1], wall_width(1), wall_height(1),
                arena_pkg::dir_up, 0, 48, px, py);
    for (int s = 0; s < 5; s++) begin
      @(posedge Clk);
      park_all();
      bullet1_x <= shifted(wall_x[1], 10);
      bullet1_y <= shifted(wall_y[1], `ARENA_VWALL_H + `ARENA_BULLET_STEP);
      bullet1_dir <= arena_pkg::dir_up;
      @(posedge Clk);
      park_all();
      tank1_x <= px;
      tank1_y <= py;
      tank1_dir <= arena_pkg::dir_up;
    end

    // bullets closing on the enemy tanks, then already past them
    for (int k = 0; k < 2; k++) begin
      @(posedge Clk);
      park_all();
      tank2_x <= 10'd600;
      tank2_y <= 10'd400;
      tank1_x <= 10'd200;
      tank1_y <= 10'd500;
      bullet1_x <= (k == 0) ? 10'd590 : 10'd640;
      bullet1_y <= 10'd410;
      bullet1_dir <= arena_pkg::dir_right;
      bullet2_x <= 10'd210;
      bullet2_y <= (k == 0) ? 10'd535 : 10'd490;
      bullet2_dir <= arena_pkg::dir_up;
    end

    // both bullets on wall 0 at once with bullet 1 also lined up with wall 2
    @(posedge Clk);
    park_all();
    bullet1_x <= 10'd110;
    bullet1_y <= 10'd137;
    bullet1_dir <= arena_pkg::dir_up;
    bullet2_x <= 10'd169;
    bullet2_y <= 10'd110;
    bullet2_dir <= arena_pkg::dir_left;
    @(posedge Clk);
    park_all();

    repeat (random_cycles) begin
      w = take_bits(2);
      d = 1 + take_bits(2);
      slip = take_bits(2);
      across = take_bits(7);
      spot_facing(wall_x[w], wall_y[w], wall_width(w), wall_height(w),
                  arena_pkg::dir_t'(d), slip, across, px, py);
      @(posedge Clk);
      tank2_x <= px;
      tank2_y <= py;
      tank2_dir <= arena_pkg::dir_t'(d);
      target = take_bits(3) % 5; // 4 means the other tank
      d = 1 + take_bits(2);
      slip = take_bits(2);
      across = take_bits(7);
      if (target == 4)
        spot_facing(px, py, tank_side, tank_side, arena_pkg::dir_t'(d), slip, across, qx, qy);
      else
        spot_facing(wall_x[target], wall_y[target], wall_width(target), wall_height(target),
                    arena_pkg::dir_t'(d), slip, across, qx, qy);
      tank1_x <= qx;
      tank1_y <= qy;
      tank1_dir <= arena_pkg::dir_t'(d);
      bullet1_x <= shifted(px, take_bits(7) - 48);
      bullet1_y <= shifted(py, take_bits(7) - 48);
      bullet1_dir <= arena_pkg::dir_t'(take_bits(3));
      bullet2_x <= shifted(qx, take_bits(7) - 48);
      bullet2_y <= shifted(qy, take_bits(7) - 48);
      bullet2_dir <= arena_pkg::dir_t'(take_bits(3));
    end

    @(posedge Clk);
    park_all();
    @(negedge Clk);
    @(posedge Clk);
    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- design/tank_arena_collision.sv
`default_nettype none
`include "arena_defines.svh"

module tank_arena_collision (
  input  logic                   Clk,
  input  logic                   Reset,
  input  arena_pkg::coord_t      wall_x [0:`ARENA_NUM_WALLS-1],
  input  arena_pkg::coord_t      wall_y [0:`ARENA_NUM_WALLS-1],
  input  arena_pkg::coord_t      tank1_x,
  input  arena_pkg::coord_t      tank1_y,
  input  arena_pkg::coord_t      tank2_x,
  input  arena_pkg::coord_t      tank2_y,
  input  arena_pkg::coord_t      bullet1_x,
  input  arena_pkg::coord_t      bullet1_y,
  input  arena_pkg::coord_t      bullet2_x,
  input  arena_pkg::coord_t      bullet2_y,
  input  arena_pkg::dir_t        tank1_dir,
  input  arena_pkg::dir_t        tank2_dir,
  input  arena_pkg::dir_t        bullet1_dir,
  input  arena_pkg::dir_t        bullet2_dir,
  output logic                   can_move1,
  output logic                   can_move2,
  output logic                   hit1,
  output logic                   hit2,
  output logic                   tank1_alive,
  output logic                   tank2_alive,
  output arena_pkg::wall_count_t wall_count [0:`ARENA_NUM_WALLS-1]
);

  arena_pkg::wall_mask_t wall_standing;
  arena_pkg::wall_mask_t wall_solid;
  arena_pkg::wall_mask_t struck1;
  arena_pkg::wall_mask_t struck2;
  logic                  tank_struck1;
  logic                  tank_struck2;

  move_checker u_move1 (
    .tank_x        (tank1_x),
    .tank_y        (tank1_y),
    .other_x       (tank2_x),
    .other_y       (tank2_y),
    .dir           (tank1_dir),
    .wall_x        (wall_x),
    .wall_y        (wall_y),
    .wall_standing (wall_standing),
    .can_move      (can_move1)
  );

  move_checker u_move2 (
    .tank_x        (tank2_x),
    .tank_y        (tank2_y),
    .other_x       (tank1_x),
    .other_y       (tank1_y),
    .dir           (tank2_dir),
    .wall_x        (wall_x),
    .wall_y        (wall_y),
    .wall_standing (wall_standing),
    .can_move      (can_move2)
  );

  bullet_checker u_bullet1 (
    .bullet_x    (bullet1_x),
    .bullet_y    (bullet1_y),
    .enemy_x     (tank2_x), // bullet 1 belongs to tank 1
    .enemy_y     (tank2_y),
    .dir         (bullet1_dir),
    .wall_x      (wall_x),
    .wall_y      (wall_y),
    .wall_solid  (wall_solid),
    .wall_struck (struck1),
    .tank_struck (tank_struck1),
    .hit         (hit1)
  );

  bullet_checker u_bullet2 (
    .bullet_x    (bullet2_x),
    .bullet_y    (bullet2_y),
    .enemy_x     (tank1_x),
    .enemy_y     (tank1_y),
    .dir         (bullet2_dir),
    .wall_x      (wall_x),
    .wall_y      (wall_y),
    .wall_solid  (wall_solid),
    .wall_struck (struck2),
    .tank_struck (tank_struck2),
    .hit         (hit2)
  );

  wall_health u_health (
    .Clk           (Clk),
    .Reset         (Reset),
    .struck_a      (struck1),
    .struck_b      (struck2),
    .wall_count    (wall_count),
    .wall_standing (wall_standing),
    .wall_solid    (wall_solid)
  );

  assign tank1_alive = ~tank_struck2;
  assign tank2_alive = ~tank_struck1;

endmodule

`default_nettype wire

//--- design/wall_health.sv
`default_nettype none
`include "arena_defines.svh"

module wall_health (
  input  logic                   Clk,
  input  logic                   Reset,
  input  arena_pkg::wall_mask_t  struck_a,
  input  arena_pkg::wall_mask_t  struck_b,
  output arena_pkg::wall_count_t wall_count [0:`ARENA_NUM_WALLS-1],
  output arena_pkg::wall_mask_t  wall_standing,
  output arena_pkg::wall_mask_t  wall_solid
);

  localparam arena_pkg::wall_count_t stand_limit = `ARENA_WALL_STAND_LIMIT;
  localparam arena_pkg::wall_count_t solid_limit = `ARENA_WALL_SOLID_LIMIT;
  localparam arena_pkg::wall_count_t dead        = `ARENA_WALL_DEAD;

  arena_pkg::wall_mask_t struck;

  assign struck = struck_a | struck_b; // two bullets on one wall count once

  always_ff @(posedge Clk or posedge Reset) begin
    if (Reset) begin
      for (int i = 0; i < `ARENA_NUM_WALLS; i++) begin
        wall_count[i] <= '0;
      end
    end else begin
      for (int i = 0; i < `ARENA_NUM_WALLS; i++) begin
        if (struck[i] && (wall_count[i] != dead)) begin
          wall_count[i] <= wall_count[i] + arena_pkg::wall_count_t'(1);
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < `ARENA_NUM_WALLS; i++) begin
      wall_standing[i] = (wall_count[i] < stand_limit);
      wall_solid[i]    = (wall_count[i] <= solid_limit);
    end
  end

  for (genvar i = 0; i < `ARENA_NUM_WALLS; i++) begin : g_chk
    a_cap: assert property (@(posedge Clk) disable iff (Reset) wall_count[i] <= dead)
      else $error("wall %0d count %0d past saturation", i, wall_count[i]);
    a_step: assert property (@(posedge Clk) disable iff (Reset)
      (wall_count[i] == $past(wall_count[i])) ||
      (wall_count[i] == $past(wall_count[i]) + 3'd1))
      else $error("wall %0d count jumped to %0d", i, wall_count[i]);
  end

endmodule

`default_nettype wire

//--- design/bullet_checker.sv
`default_nettype none
`include "arena_defines.svh"

module bullet_checker (
  input  arena_pkg::coord_t     bullet_x,
  input  arena_pkg::coord_t     bullet_y,
  input  arena_pkg::coord_t     enemy_x,
  input  arena_pkg::coord_t     enemy_y,
  input  arena_pkg::dir_t       dir,
  input  arena_pkg::coord_t     wall_x [0:`ARENA_NUM_WALLS-1],
  input  arena_pkg::coord_t     wall_y [0:`ARENA_NUM_WALLS-1],
  input  arena_pkg::wall_mask_t wall_solid,
  output arena_pkg::wall_mask_t wall_struck,
  output logic                  tank_struck,
  output logic                  hit
);

  localparam arena_pkg::coord_t side      = arena_pkg::coord_t'(`ARENA_BULLET_SIZE);
  localparam arena_pkg::coord_t step      = arena_pkg::coord_t'(`ARENA_BULLET_STEP);
  localparam arena_pkg::coord_t tank_side = arena_pkg::coord_t'(`ARENA_TANK_SIZE);

  arena_pkg::wall_mask_t reach_mask;

  // lead and tail are the stepped front and back edges
  function automatic logic reaches(
    input arena_pkg::dir_t   d,
    input arena_pkg::coord_t bx,
    input arena_pkg::coord_t by,
    input arena_pkg::coord_t tx,
    input arena_pkg::coord_t ty,
    input arena_pkg::coord_t tw,
    input arena_pkg::coord_t th,
    input logic              check_pass
  );
    arena_pkg::coord_t t_right;
    arena_pkg::coord_t t_bottom;
    arena_pkg::coord_t lead;
    arena_pkg::coord_t tail;
    logic              x_ovl;
    logic              y_ovl;
    t_right  = tx + tw;
    t_bottom = ty + th;
    x_ovl    = (arena_pkg::coord_t'(bx + side) > tx) && (bx < t_right);
    y_ovl    = (arena_pkg::coord_t'(by + side) > ty) && (by < t_bottom);
    lead     = '0;
    tail     = '0;
    reaches  = 1'b0;
    case (d)
      arena_pkg::dir_up: begin
        lead    = by - step;
        tail    = lead + side;
        reaches = (lead <= t_bottom) && x_ovl && (!check_pass || tail >= ty);
      end
      arena_pkg::dir_down: begin
        tail    = by + step;
        lead    = tail + side;
        reaches = (lead >= ty) && x_ovl && (!check_pass || tail <= t_bottom);
      end
      arena_pkg::dir_right: begin
        tail    = bx + step;
        lead    = tail + side;
        reaches = (lead >= tx) && y_ovl && (!check_pass || tail <= t_right);
      end
      arena_pkg::dir_left: begin
        lead    = bx - step;
        tail    = lead + side;
        reaches = (lead <= t_right) && y_ovl && (!check_pass || tail >= tx);
      end
      default: reaches = 1'b0;
    endcase
    return reaches;
  endfunction

  always_comb begin
    for (int i = 0; i < `ARENA_NUM_WALLS; i++) begin
      reach_mask[i] = wall_solid[i] &&
                      reaches(dir, bullet_x, bullet_y, wall_x[i], wall_y[i],
                              arena_pkg::wall_w(i), arena_pkg::wall_h(i), 1'b0);
    end
  end

  assign wall_struck = reach_mask & (-reach_mask); // lowest index wins

  assign tank_struck = reaches(dir, bullet_x, bullet_y, enemy_x, enemy_y,
                               tank_side, tank_side, 1'b1);
  assign hit = (|wall_struck) | tank_struck;

  // one reached wall kept whenever any is reached
  always_comb begin
    assert ($isunknown(reach_mask) ||
            ($onehot0(wall_struck) && ((wall_struck & ~reach_mask) == '0) &&
             ((wall_struck == '0) == (reach_mask == '0))))
      else $error("wall_struck %b not one bit of reached %b", wall_struck, reach_mask);
  end

endmodule

`default_nettype wire

//--- design/move_checker.sv
`default_nettype none
`include "arena_defines.svh"

module move_checker (
  input  arena_pkg::coord_t     tank_x,
  input  arena_pkg::coord_t     tank_y,
  input  arena_pkg::coord_t     other_x,
  input  arena_pkg::coord_t     other_y,
  input  arena_pkg::dir_t       dir,
  input  arena_pkg::coord_t     wall_x [0:`ARENA_NUM_WALLS-1],
  input  arena_pkg::coord_t     wall_y [0:`ARENA_NUM_WALLS-1],
  input  arena_pkg::wall_mask_t wall_standing,
  output logic                  can_move
);

  localparam arena_pkg::coord_t tank_side = arena_pkg::coord_t'(`ARENA_TANK_SIZE);
  localparam arena_pkg::coord_t step      = arena_pkg::coord_t'(`ARENA_TANK_STEP);

  logic blocked;

  // stepped leading edge lands exactly on the target face
  function automatic logic contact(
    input arena_pkg::dir_t   d,
    input arena_pkg::coord_t px,
    input arena_pkg::coord_t py,
    input arena_pkg::coord_t tx,
    input arena_pkg::coord_t ty,
    input arena_pkg::coord_t tw,
    input arena_pkg::coord_t th
  );
    arena_pkg::coord_t t_right;
    arena_pkg::coord_t t_bottom;
    arena_pkg::coord_t lead;
    logic              x_ovl;
    logic              y_ovl;
    t_right  = tx + tw;
    t_bottom = ty + th;
    x_ovl    = (arena_pkg::coord_t'(px + tank_side) > tx) && (px < t_right);
    y_ovl    = (arena_pkg::coord_t'(py + tank_side) > ty) && (py < t_bottom);
    lead     = '0;
    contact  = 1'b0;
    case (d)
      arena_pkg::dir_up: begin
        lead    = py - step;
        contact = (lead == t_bottom) && x_ovl;
      end
      arena_pkg::dir_down: begin
        lead    = py + tank_side + step;
        contact = (lead == ty) && x_ovl;
      end
      arena_pkg::dir_right: begin
        lead    = px + tank_side + step;
        contact = (lead == tx) && y_ovl;
      end
      arena_pkg::dir_left: begin
        lead    = px - step;
        contact = (lead == t_right) && y_ovl;
      end
      default: contact = 1'b0; // idle or unknown code never blocks
    endcase
    return contact;
  endfunction

  always_comb begin
    blocked = contact(dir, tank_x, tank_y, other_x, other_y, tank_side, tank_side);
    for (int i = 0; i < `ARENA_NUM_WALLS; i++) begin
      if (wall_standing[i] &&
          contact(dir, tank_x, tank_y, wall_x[i], wall_y[i],
                  arena_pkg::wall_w(i), arena_pkg::wall_h(i))) begin
        blocked = 1'b1;
      end
    end
  end

  assign can_move = ~blocked;

endmodule

`default_nettype wire

//--- design/arena_pkg.sv
`default_nettype none
`include "arena_defines.svh"

package arena_pkg;

  typedef logic [`ARENA_COORD_W-1:0] coord_t;

  typedef enum logic [2:0] {
    dir_idle  = 3'd0,
    dir_up    = 3'd1,
    dir_right = 3'd2,
    dir_left  = 3'd3,
    dir_down  = 3'd4
  } dir_t;

  typedef logic [$clog2(`ARENA_WALL_DEAD+1)-1:0] wall_count_t;
  typedef logic [`ARENA_NUM_WALLS-1:0] wall_mask_t;

  // wall shape follows from its index
  function automatic coord_t wall_w(input int idx);
    return (idx % 2 == 0) ? coord_t'(`ARENA_HWALL_W) : coord_t'(`ARENA_VWALL_W);
  endfunction

  function automatic coord_t wall_h(input int idx);
    return (idx % 2 == 0) ? coord_t'(`ARENA_HWALL_H) : coord_t'(`ARENA_VWALL_H);
  endfunction

endpackage

`default_nettype wire

//--- include/arena_defines.svh
`ifndef ARENA_DEFINES_SVH
`define ARENA_DEFINES_SVH

// screen coordinates wrap at 1024
`define ARENA_COORD_W 10

`define ARENA_TANK_SIZE   32
`define ARENA_BULLET_SIZE 8

// walls 0 and 2 lie flat
`define ARENA_HWALL_W 64
`define ARENA_HWALL_H 32

// walls 1 and 3 stand upright
`define ARENA_VWALL_W 32
`define ARENA_VWALL_H 64

`define ARENA_TANK_STEP   1
`define ARENA_BULLET_STEP 5

`define ARENA_NUM_WALLS 4

// count below this still blocks tanks
`define ARENA_WALL_STAND_LIMIT 3
// count at or below this still stops bullets
`define ARENA_WALL_SOLID_LIMIT 3
`define ARENA_WALL_DEAD        4

`endif
